/* sources.f */
src/usb_tx_pkg.sv
src/token_builder.sv
src/tx_payload_fifo.sv
src/encode_packet.sv
src/usb_tx_top.sv
verif/usb_tx_tb.sv

/* src/encode_packet.sv */
`timescale 1ns/1ns

module encode_packet import usb_tx_pkg::*; #(
  parameter bit TOKEN = 1'b0
) (
  input  logic            clock,
  input  logic            reset,

  output logic            enc_busy_o,

  output logic            tx_tvalid_o,
  input  logic            tx_tready_i,
  output logic            tx_tlast_o,
  output logic [7:0]      tx_tdata_o,

  input  hsk_type_e       hsk_type_i,
  input  logic            hsk_send_i,
  output logic            hsk_done_o,

  input  logic            tok_send_i,
  output logic            tok_done_o,
  input  tok_type_e       tok_type_i,
  input  usb_token_word_u tok_word_i,

  input  dat_type_e       dat_type_i,
  input  logic            dat_send_i,
  output logic            dat_done_o,

  input  logic            trn_tvalid_i,
  output logic            trn_tready_o,
  input  logic            trn_tlast_i,
  input  logic            trn_tkeep_i,
  input  logic [7:0]      trn_tdata_i
);

  // One-hot state bits
  localparam int S_IDLE = 0;
  localparam int S_HSK  = 1;
  localparam int S_TOK  = 2;
  localparam int S_DATA = 3;

  localparam logic [3:0] ST_IDLE = 4'b0001;
  localparam logic [3:0] ST_HSK  = 4'b0010;
  localparam logic [3:0] ST_TOK  = 4'b0100;
  localparam logic [3:0] ST_DATA = 4'b1000;

  // Body phase for token and data packets
  // FIRST holds the PID or payload, LOW and HIGH the two trailing bytes
  localparam logic [1:0] PH_FIRST = 2'd0;
  localparam logic [1:0] PH_LOW   = 2'd1;
  localparam logic [1:0] PH_HIGH  = 2'd2;
  localparam logic [1:0] PH_END   = 2'd3;

  logic [3:0]  state_q;
  logic [1:0]  phase_q;

  // Output byte register
  logic        tvalid_q;
  logic        tlast_q;
  logic [7:0]  tdata_q;

  // Skid register for one payload byte
  logic        skid_valid_q;
  logic [7:0]  skid_data_q;
  logic        last_seen_q;

  logic [15:0] crc16_q;
  logic [15:0] crc16_tx;

  logic        hsk_done_q;
  logic        tok_done_q;
  logic        dat_done_q;

  logic        out_xfer;
  logic        out_free;
  logic        in_xfer;
  logic        in_byte;

  // Low nibble is type and pair, high nibble its complement
  function automatic logic [7:0] pid_byte(input logic [1:0] kind, input logic [1:0] pair);
    return {~kind, ~pair, kind, pair};
  endfunction

  assign enc_busy_o  = !state_q[S_IDLE];

  assign tx_tvalid_o = tvalid_q;
  assign tx_tlast_o  = tlast_q;
  assign tx_tdata_o  = tdata_q;

  assign hsk_done_o  = hsk_done_q;
  assign tok_done_o  = tok_done_q;
  assign dat_done_o  = dat_done_q;

  assign out_xfer = tvalid_q && tx_tready_i;
  assign out_free = !tvalid_q || tx_tready_i;

  // Payload is taken only while the skid is empty and the last beat is not yet in
  assign trn_tready_o = state_q[S_DATA] && (phase_q == PH_FIRST) &&
                        !skid_valid_q && !last_seen_q;
  assign in_xfer = trn_tvalid_i && trn_tready_o;
  // Beats without keep carry no byte
  assign in_byte = in_xfer && trn_tkeep_i;

  // CRC16 goes out inverted and bit reversed
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc16_tx[i] = ~crc16_q[15-i];
    end
  end

  always_ff @(posedge clock) begin
    if (!state_q[S_DATA]) begin
      crc16_q <= 16'hffff;
    end else if (in_byte) begin
      crc16_q <= crc16(trn_tdata_i, crc16_q);
    end
  end

  // Handshake and token done hold until their send level drops
  always_ff @(posedge clock) begin
    if (reset || !hsk_send_i) begin
      hsk_done_q <= 1'b0;
    end else if (state_q[S_HSK] && out_xfer) begin
      hsk_done_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || !tok_send_i) begin
      tok_done_q <= 1'b0;
    end else if (state_q[S_TOK] && out_xfer && tlast_q) begin
      tok_done_q <= 1'b1;
    end
  end

  // Single cycle pulse after the second CRC byte leaves
  always_ff @(posedge clock) begin
    if (reset) begin
      dat_done_q <= 1'b0;
    end else begin
      dat_done_q <= state_q[S_DATA] && (phase_q == PH_HIGH) && out_xfer;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= ST_IDLE;
      phase_q      <= PH_FIRST;
      tvalid_q     <= 1'b0;
      tlast_q      <= 1'b0;
      skid_valid_q <= 1'b0;
      last_seen_q  <= 1'b0;
    end else begin
      case (1'b1)
        state_q[S_HSK]: begin
          if (out_xfer) begin
            tvalid_q <= 1'b0;
            tlast_q  <= 1'b0;
          end
          if (!hsk_send_i && !tvalid_q) begin
            state_q <= ST_IDLE;
          end
        end

        state_q[S_TOK]: begin
          if (out_xfer) begin
            case (phase_q)
              PH_FIRST: begin
                tdata_q <= tok_word_i[7:0];
                phase_q <= PH_LOW;
              end
              PH_LOW: begin
                tdata_q <= tok_word_i[15:8];
                tlast_q <= 1'b1;
                phase_q <= PH_HIGH;
              end
              default: begin
                tvalid_q <= 1'b0;
                tlast_q  <= 1'b0;
                phase_q  <= PH_END;
              end
            endcase
          end
          if (!tok_send_i && phase_q == PH_END) begin
            state_q <= ST_IDLE;
          end
        end

        state_q[S_DATA]: begin
          case (phase_q)
            PH_FIRST: begin
              if (out_free) begin
                // Skid byte first, then a fresh beat, then the CRC
                if (skid_valid_q) begin
                  tvalid_q     <= 1'b1;
                  tdata_q      <= skid_data_q;
                  skid_valid_q <= 1'b0;
                end else if (in_byte) begin
                  tvalid_q <= 1'b1;
                  tdata_q  <= trn_tdata_i;
                end else if (last_seen_q) begin
                  tvalid_q <= 1'b1;
                  tdata_q  <= crc16_tx[7:0];
                  phase_q  <= PH_LOW;
                end else begin
                  tvalid_q <= 1'b0;
                end
              end else if (in_byte) begin
                // Output is stalled so park the byte
                skid_valid_q <= 1'b1;
                skid_data_q  <= trn_tdata_i;
              end
              if (in_xfer && trn_tlast_i) begin
                last_seen_q <= 1'b1;
              end
            end
            PH_LOW: begin
              if (out_xfer) begin
                tdata_q <= crc16_tx[15:8];
                tlast_q <= 1'b1;
                phase_q <= PH_HIGH;
              end
            end
            PH_HIGH: begin
              if (out_xfer) begin
                tvalid_q <= 1'b0;
                tlast_q  <= 1'b0;
                phase_q  <= PH_END;
              end
            end
            default: begin
              // Wait for the requester to drop send
              if (!dat_send_i) begin
                state_q <= ST_IDLE;
              end
            end
          endcase
        end

        default: begin
          phase_q     <= PH_FIRST;
          last_seen_q <= 1'b0;
          // Handshake wins over token, token over data
          if (hsk_send_i) begin
            state_q  <= ST_HSK;
            tvalid_q <= 1'b1;
            tlast_q  <= 1'b1;
            tdata_q  <= pid_byte(hsk_type_i, PID_PAIR_HSK);
          end else if (TOKEN && tok_send_i) begin
            state_q  <= ST_TOK;
            tvalid_q <= 1'b1;
            tlast_q  <= 1'b0;
            tdata_q  <= pid_byte(tok_type_i, PID_PAIR_TOK);
          end else if (dat_send_i) begin
            state_q  <= ST_DATA;
            tvalid_q <= 1'b1;
            tlast_q  <= 1'b0;
            tdata_q  <= pid_byte(dat_type_i, PID_PAIR_DAT);
          end
        end
      endcase
    end
  end

endmodule

/* src/token_builder.sv */
`timescale 1ns/1ns

module token_builder import usb_tx_pkg::*; (
  input  logic            clock,
  input  logic            reset,

  input  logic            tok_send_i,
  input  usb_token_req_t  tok_req_i,

  output logic            tok_send_o,
  output tok_type_e       tok_type_o,
  output usb_token_word_u tok_word_o
);

  usb_token_req_t req_q;

  // Capture the request in the first cycle of a new send
  always_ff @(posedge clock) begin
    if (tok_send_i && !tok_send_o) begin
      req_q <= tok_req_i;
    end
  end

  // Send toward the encoder trails the outside request by one cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      tok_send_o <= 1'b0;
    end else begin
      tok_send_o <= tok_send_i;
    end
  end

  assign tok_type_o = req_q.tok_type;

  // SOF carries the frame number, all other tokens carry address and endpoint
  always_comb begin
    tok_word_o = '0;
    if (req_q.tok_type == TOK_SOF) begin
      tok_word_o.sof.frame = req_q.frame;
      tok_word_o.sof.crc5  = crc5(req_q.frame);
    end else begin
      tok_word_o.ae.addr = req_q.addr;
      tok_word_o.ae.endp = req_q.endp;
      tok_word_o.ae.crc5 = crc5({req_q.endp, req_q.addr});
    end
  end

endmodule

/* src/tx_payload_fifo.sv */
`timescale 1ns/1ns

module tx_payload_fifo import usb_tx_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic         clock,
  input  logic         reset,

  input  logic         wr_i,
  input  usb_payload_t wr_data_i,
  output logic         full_o,

  output logic         tvalid_o,
  input  logic         tready_i,
  output logic         tlast_o,
  output logic         tkeep_o,
  output logic [7:0]   tdata_o
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PW-1:0] LAST_IDX = PW'(FIFO_DEPTH - 1);
  localparam logic [PW:0]   DEPTH    = (PW + 1)'(FIFO_DEPTH);

  usb_payload_t  mem_q [FIFO_DEPTH];
  usb_payload_t  head;
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW:0]   count_q;
  logic          push;
  logic          pop;

  assign full_o   = (count_q == DEPTH);
  assign tvalid_o = (count_q != '0);

  // Writes into a full buffer are dropped
  assign push = wr_i && !full_o;
  assign pop  = tvalid_o && tready_i;

  assign head    = mem_q[rd_ptr_q];
  assign tdata_o = head.data;
  assign tlast_o = head.last;
  assign tkeep_o = head.keep;

  always_ff @(posedge clock) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap explicitly so any depth works
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* src/usb_tx_pkg.sv */
package usb_tx_pkg;

  // PID type field, the upper pair of the low PID nibble
  typedef enum logic [1:0] {
    HSK_ACK   = 2'b00,
    HSK_NAK   = 2'b10,
    HSK_STALL = 2'b11
  } hsk_type_e;

  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_IN    = 2'b10,
    TOK_SOF   = 2'b01,
    TOK_SETUP = 2'b11
  } tok_type_e;

  typedef enum logic [1:0] {
    DAT_DATA0 = 2'b00,
    DAT_DATA1 = 2'b10,
    DAT_DATA2 = 2'b01,
    DAT_MDATA = 2'b11
  } dat_type_e;

  // Fixed low pair of the PID for each packet kind
  localparam logic [1:0] PID_PAIR_HSK = 2'b10;
  localparam logic [1:0] PID_PAIR_TOK = 2'b01;
  localparam logic [1:0] PID_PAIR_DAT = 2'b11;

  typedef struct packed {
    tok_type_e   tok_type;
    logic [6:0]  addr;
    logic [3:0]  endp;
    logic [10:0] frame;
  } usb_token_req_t;

  // Token word in wire order, bit 0 leaves first
  typedef struct packed {
    logic [4:0] crc5;
    logic [3:0] endp;
    logic [6:0] addr;
  } usb_token_ae_t;

  typedef struct packed {
    logic [4:0]  crc5;
    logic [10:0] frame;
  } usb_token_sof_t;

  typedef union packed {
    usb_token_ae_t  ae;
    usb_token_sof_t sof;
  } usb_token_word_u;

  // One payload FIFO entry or stream beat
  typedef struct packed {
    logic [7:0] data;
    logic       last;
    logic       keep;
  } usb_payload_t;

  // USB CRC5 over the 11 token field bits, LSB first
  function automatic logic [4:0] crc5(input logic [10:0] din);
    logic [4:0] c;
    logic       fb;
    c = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb = din[i] ^ c[4];
      c  = fb ? ({c[3:0], 1'b0} ^ 5'h05) : {c[3:0], 1'b0};
    end
    // Residue goes out inverted and highest bit first
    return ~{c[0], c[1], c[2], c[3], c[4]};
  endfunction

  // One byte step of the USB CRC16, LSB first
  function automatic logic [15:0] crc16(input logic [7:0] din, input logic [15:0] state);
    logic [15:0] c;
    logic        fb;
    c = state;
    for (int i = 0; i < 8; i++) begin
      fb = din[i] ^ c[15];
      c  = fb ? ({c[14:0], 1'b0} ^ 16'h8005) : {c[14:0], 1'b0};
    end
    return c;
  endfunction

endpackage

/* src/usb_tx_top.sv */
`timescale 1ns/1ns

module usb_tx_top import usb_tx_pkg::*; #(
  parameter bit TOKEN      = 1'b1,
  parameter int FIFO_DEPTH = 16
) (
  input  logic           clock,
  input  logic           reset,

  input  logic           hsk_send_i,
  input  hsk_type_e      hsk_type_i,
  output logic           hsk_done_o,

  input  logic           tok_send_i,
  input  usb_token_req_t tok_req_i,
  output logic           tok_done_o,

  input  logic           dat_send_i,
  input  dat_type_e      dat_type_i,
  output logic           dat_done_o,

  input  logic           pay_wr_i,
  input  usb_payload_t   pay_i,
  output logic           pay_full_o,

  output logic           tx_tvalid_o,
  input  logic           tx_tready_i,
  output logic           tx_tlast_o,
  output logic [7:0]     tx_tdata_o,

  output logic           enc_busy_o
);

  logic            tok_send;
  tok_type_e       tok_type;
  usb_token_word_u tok_word;

  logic            pay_tvalid;
  logic            pay_tready;
  logic            pay_tlast;
  logic            pay_tkeep;
  logic [7:0]      pay_tdata;

  // Without token support the encoder never sees a token request
  generate
    if (TOKEN) begin : g_token
      token_builder u_token_builder (
        .clock      (clock),
        .reset      (reset),
        .tok_send_i (tok_send_i),
        .tok_req_i  (tok_req_i),
        .tok_send_o (tok_send),
        .tok_type_o (tok_type),
        .tok_word_o (tok_word)
      );
    end else begin : g_no_token
      assign tok_send = 1'b0;
      assign tok_type = TOK_OUT;
      assign tok_word = '0;
    end
  endgenerate

  tx_payload_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_payload_fifo (
    .clock     (clock),
    .reset     (reset),
    .wr_i      (pay_wr_i),
    .wr_data_i (pay_i),
    .full_o    (pay_full_o),
    .tvalid_o  (pay_tvalid),
    .tready_i  (pay_tready),
    .tlast_o   (pay_tlast),
    .tkeep_o   (pay_tkeep),
    .tdata_o   (pay_tdata)
  );

  encode_packet #(
    .TOKEN (TOKEN)
  ) u_encode_packet (
    .clock        (clock),
    .reset        (reset),
    .enc_busy_o   (enc_busy_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tready_i  (tx_tready_i),
    .tx_tlast_o   (tx_tlast_o),
    .tx_tdata_o   (tx_tdata_o),
    .hsk_type_i   (hsk_type_i),
    .hsk_send_i   (hsk_send_i),
    .hsk_done_o   (hsk_done_o),
    .tok_send_i   (tok_send),
    .tok_done_o   (tok_done_o),
    .tok_type_i   (tok_type),
    .tok_word_i   (tok_word),
    .dat_type_i   (dat_type_i),
    .dat_send_i   (dat_send_i),
    .dat_done_o   (dat_done_o),
    .trn_tvalid_i (pay_tvalid),
    .trn_tready_o (pay_tready),
    .trn_tlast_i  (pay_tlast),
    .trn_tkeep_i  (pay_tkeep),
    .trn_tdata_i  (pay_tdata)
  );

endmodule

/* verif/usb_tx_golden.txt */
# name kind type dtype addr endp frame npay payload... nexp expected...
# all hex, kind H T D or P, dtype is the data PID type of a P line
h_ack H 0 0 00 0 000 00 01 D2
h_nak H 2 0 00 0 000 00 01 5A
h_stall H 3 0 00 0 000 00 01 1E
t_out T 0 0 01 0 123 00 03 E1 01 E8
t_in T 2 0 01 1 000 00 03 69 81 58
t_setup T 3 0 00 0 7FF 00 03 2D 00 10
t_sof T 1 0 55 A 7FF 00 03 A5 FF 47
d_data0_1 D 0 0 00 0 000 01 01 04 C3 01 81 7F
d_data1_2 D 2 0 00 0 000 02 01 03 05 4B 01 03 BF DE
d_data2_6 D 1 0 00 0 000 06 01 03 00 00 00 01 09 87 01 03 00 00 00 01 7B F5
d_mdata_6 D 3 0 00 0 000 06 01 03 00 00 00 0A 09 0F 01 03 00 00 00 0A 3A 32
d_data1_12 D 2 0 00 0 000 0C 01 03 00 00 00 0A C5 CD 40 19 01 B6 0F 4B 01 03 00 00 00 0A C5 CD 40 19 01 B6 BB DE
d_empty D 2 0 00 0 000 00 03 4B 00 00
p_ack_data1 P 0 2 00 0 000 01 01 05 D2 4B 01 81 7F

/* verif/usb_tx_tb.sv */
`timescale 1ns/1ns

module usb_tx_tb
  import usb_tx_pkg::*;
();

  localparam int MAX_TESTS  = 32;
  localparam int TIMEOUT    = 200;
  localparam int FIFO_DEPTH = 16;
  localparam int SIG_HSK    = 0;
  localparam int SIG_TOK    = 1;
  localparam int SIG_DAT    = 2;
  localparam int SIG_BUSY   = 3;

  logic           clock;
  logic           reset;
  logic           hsk_send;
  hsk_type_e      hsk_type;
  logic           hsk_done;
  logic           tok_send;
  usb_token_req_t tok_req;
  logic           tok_done;
  logic           dat_send;
  dat_type_e      dat_type;
  logic           dat_done;
  logic           pay_wr;
  usb_payload_t   pay;
  logic           pay_full;
  logic           tx_tvalid;
  logic           tx_tready;
  logic           tx_tlast;
  logic [7:0]     tx_tdata;
  logic           enc_busy;

  logic [8:0]     got_q [$];
  logic [31:0]    lfsr_q;
  logic           bp_mode;
  logic           aborted;
  int             err_total;
  int             tests_run;
  int             tests_failed;

  // Test table loaded from the golden file
  int             n_tests;
  string          name_a  [MAX_TESTS];
  string          kind_a  [MAX_TESTS];
  logic [1:0]     type_a  [MAX_TESTS];
  logic [1:0]     dtype_a [MAX_TESTS];
  logic [6:0]     addr_a  [MAX_TESTS];
  logic [3:0]     endp_a  [MAX_TESTS];
  logic [10:0]    frame_a [MAX_TESTS];
  int             npay_a  [MAX_TESTS];
  logic [7:0]     pay_a   [MAX_TESTS][16];
  int             nexp_a  [MAX_TESTS];
  logic [7:0]     exp_a   [MAX_TESTS][24];

  usb_tx_top #(
    .TOKEN      (1'b1),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut_i (
    .clock       (clock),
    .reset       (reset),
    .hsk_send_i  (hsk_send),
    .hsk_type_i  (hsk_type),
    .hsk_done_o  (hsk_done),
    .tok_send_i  (tok_send),
    .tok_req_i   (tok_req),
    .tok_done_o  (tok_done),
    .dat_send_i  (dat_send),
    .dat_type_i  (dat_type),
    .dat_done_o  (dat_done),
    .pay_wr_i    (pay_wr),
    .pay_i       (pay),
    .pay_full_o  (pay_full),
    .tx_tvalid_o (tx_tvalid),
    .tx_tready_i (tx_tready),
    .tx_tlast_o  (tx_tlast),
    .tx_tdata_o  (tx_tdata),
    .enc_busy_o  (enc_busy)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Random ready on the back-pressure pass, one LFSR step per bit
  always @(posedge clock) begin
    #1;
    if (bp_mode) begin
      lfsr_q    = lfsr_step(lfsr_q);
      tx_tready = lfsr_q[0];
    end else begin
      tx_tready = 1'b1;
    end
  end

  // Byte monitor, last flag kept in bit 8
  always @(posedge clock) begin
    if (!reset && tx_tvalid && tx_tready) begin
      got_q.push_back({tx_tlast, tx_tdata});
    end
  end

  function automatic logic sig_value(input int which);
    case (which)
      SIG_HSK: return hsk_done;
      SIG_TOK: return tok_done;
      SIG_DAT: return dat_done;
      default: return enc_busy;
    endcase
  endfunction

  task automatic wait_sig(input int which, input logic level, input string tname,
                          input string what);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    if (aborted) begin
      return;
    end
    while (!seen && n < TIMEOUT) begin
      @(posedge clock);
      seen = (sig_value(which) === level);
      n++;
    end
    #1;
    if (!seen) begin
      $display("Test %s timed out after %0d cycles waiting for %s", tname, TIMEOUT, what);
      aborted = 1'b1;
    end
  endtask

  task automatic load_golden();
    int               fd;
    int               code;
    string            tok;
    logic [8*200-1:0] line_buf;
    n_tests = 0;
    fd = $fopen("verif/usb_tx_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file verif/usb_tx_golden.txt");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        break;
      end
      if (tok.substr(0, 0) == "#") begin
        code = $fgets(line_buf, fd);
        continue;
      end
      name_a[n_tests] = tok;
      code = $fscanf(fd, "%s %h %h %h %h %h %h", kind_a[n_tests], type_a[n_tests],
                     dtype_a[n_tests], addr_a[n_tests], endp_a[n_tests],
                     frame_a[n_tests], npay_a[n_tests]);
      if (code != 7) begin
        $display("Golden file line for test %s is malformed", tok);
        aborted = 1'b1;
        break;
      end
      for (int i = 0; i < npay_a[n_tests]; i++) begin
        code = $fscanf(fd, "%h", pay_a[n_tests][i]);
      end
      code = $fscanf(fd, "%h", nexp_a[n_tests]);
      for (int i = 0; i < nexp_a[n_tests]; i++) begin
        code = $fscanf(fd, "%h", exp_a[n_tests][i]);
      end
      n_tests++;
    end
    $fclose(fd);
  endtask

  // An empty payload is a single beat with keep low and last high
  task automatic write_payload(input int t);
    int i;
    pay_wr = 1'b1;
    if (npay_a[t] == 0) begin
      pay.data = 8'h00;
      pay.last = 1'b1;
      pay.keep = 1'b0;
      @(posedge clock);
      #1;
    end else begin
      for (i = 0; i < npay_a[t]; i++) begin
        pay.data = pay_a[t][i];
        pay.last = (i == npay_a[t] - 1);
        pay.keep = 1'b1;
        @(posedge clock);
        #1;
      end
    end
    pay_wr = 1'b0;
    pay    = '0;
  endtask

  task automatic run_test(input int t, input string tname);
    int         errs;
    int         i;
    int         n_fill;
    logic       exp_full;
    logic       exp_last;
    logic [8:0] exp_word;
    errs = 0;
    got_q.delete();
    hsk_type         = hsk_type_e'(type_a[t]);
    tok_req.tok_type = tok_type_e'(type_a[t]);
    tok_req.addr     = addr_a[t];
    tok_req.endp     = endp_a[t];
    tok_req.frame    = frame_a[t];
    dat_type = dat_type_e'((kind_a[t] == "P") ? dtype_a[t] : type_a[t]);
    if (kind_a[t] == "D" || kind_a[t] == "P") begin
      write_payload(t);
      // The encoder takes nothing before its send, so the FIFO holds every entry
      n_fill   = (npay_a[t] == 0) ? 1 : npay_a[t];
      exp_full = (n_fill == FIFO_DEPTH);
      assert (pay_full === exp_full) else begin
        $display("Fail %s pay_full_o expected %b actual %b", tname, exp_full, pay_full);
        errs++;
      end
    end
    if (kind_a[t] == "H") begin
      hsk_send = 1'b1;
      wait_sig(SIG_HSK, 1'b1, tname, "hsk_done_o to rise");
      hsk_send = 1'b0;
      wait_sig(SIG_HSK, 1'b0, tname, "hsk_done_o to fall");
    end else if (kind_a[t] == "T") begin
      tok_send = 1'b1;
      wait_sig(SIG_TOK, 1'b1, tname, "tok_done_o to rise");
      tok_send = 1'b0;
      wait_sig(SIG_TOK, 1'b0, tname, "tok_done_o to fall");
    end else begin
      // Priority case raises both sends, the handshake must go first
      if (kind_a[t] == "P") begin
        hsk_send = 1'b1;
        dat_send = 1'b1;
        wait_sig(SIG_HSK, 1'b1, tname, "hsk_done_o to rise");
        hsk_send = 1'b0;
        wait_sig(SIG_HSK, 1'b0, tname, "hsk_done_o to fall");
      end else begin
        dat_send = 1'b1;
      end
      wait_sig(SIG_DAT, 1'b1, tname, "dat_done_o to rise");
      if (!aborted) begin
        @(posedge clock);
        assert (dat_done === 1'b0) else begin
          $display("Test %s: dat_done_o stayed high for more than one cycle", tname);
          errs++;
        end
        #1;
      end
      dat_send = 1'b0;
    end
    wait_sig(SIG_BUSY, 1'b0, tname, "the encoder to go idle");

    assert (got_q.size() == nexp_a[t]) else begin
      $display("Fail %s byte count expected %0d actual %0d", tname, nexp_a[t], got_q.size());
      errs++;
    end
    for (i = 0; i < nexp_a[t] && i < got_q.size(); i++) begin
      exp_last = (i == nexp_a[t] - 1) || (kind_a[t] == "P" && i == 0);
      exp_word = {exp_last, exp_a[t][i]};
      assert (got_q[i] === exp_word) else begin
        $display("Fail %s byte %0d expected %h last %b actual %h last %b", tname, i,
                 exp_word[7:0], exp_word[8], got_q[i][7:0], got_q[i][8]);
        errs++;
      end
    end
    if (aborted) begin
      errs++;
    end
    tests_run++;
    err_total += errs;
    if (errs == 0) begin
      $display("%-16s pass", tname);
    end else begin
      tests_failed++;
      $display("%-16s fail with %0d errors", tname, errs);
    end
  endtask

  initial begin
    string tname;
    reset        = 1'b1;
    hsk_send     = 1'b0;
    hsk_type     = HSK_ACK;
    tok_send     = 1'b0;
    tok_req      = '0;
    dat_send     = 1'b0;
    dat_type     = DAT_DATA0;
    pay_wr       = 1'b0;
    pay          = '0;
    tx_tready    = 1'b1;
    bp_mode      = 1'b0;
    lfsr_q       = 32'h756b6050;
    aborted      = 1'b0;
    err_total    = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_golden();
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    assert (!tx_tvalid && !hsk_done && !tok_done && !dat_done && !enc_busy &&
            !dut_i.pay_tready) else begin
      $display("Outputs were not idle after reset");
      err_total++;
    end
    assert (n_tests > 0) else begin
      $display("No tests were read from the golden file");
      err_total++;
    end
    // Second pass repeats every stream under random back-pressure
    for (int pass = 0; pass < 2; pass++) begin
      bp_mode = (pass == 1);
      for (int t = 0; t < n_tests; t++) begin
        tname = (pass == 1) ? {name_a[t], "_bp"} : name_a[t];
        if (!aborted) begin
          run_test(t, tname);
        end
      end
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
    if (err_total == 0 && !aborted) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
